// File: src/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    // device geometry.
    localparam int ROW_BITS = 13;
    localparam int COL_BITS = 9;
    localparam int BANK_BITS = 2;
    localparam int WORD_COL_BITS = 8; // two 16 bit beats per word.
    localparam int DQ_BITS = 16;
    localparam int DQM_BITS = 2;
    localparam int ADDR_BITS = ROW_BITS + BANK_BITS + WORD_COL_BITS;

    localparam int CAS_LATENCY = 2;
    localparam int ACTIVATE_LATENCY = 2;
    localparam int PRECHARGE_LATENCY = 2;
    localparam int AUTOREFRESH_LATENCY = 3;

    localparam int CLK_FREQUENCY = 50000000;
    localparam int INIT_CYCLES = CLK_FREQUENCY / 1000000 * 100; // 100 us.
    localparam int REFRESH_INTERVAL = CLK_FREQUENCY / 1000000 * 78 / 10; // 7.8 us.

    localparam logic [ROW_BITS-1:0] MODE_REGISTER_VALUE = 'h21; // cl 2, burst 2.
    localparam logic [ROW_BITS-1:0] AUTO_PRECHARGE = 'h400; // a10.

    // wait counts for the sequencer.
    localparam int LAT_BITS = 3;
    localparam logic [LAT_BITS-1:0] LAT_ACTIVATE = LAT_BITS'(ACTIVATE_LATENCY);
    localparam logic [LAT_BITS-1:0] LAT_PRECHARGE = LAT_BITS'(PRECHARGE_LATENCY);
    localparam logic [LAT_BITS-1:0] LAT_REFRESH = LAT_BITS'(AUTOREFRESH_LATENCY);
    localparam logic [LAT_BITS-1:0] LAT_MODE = LAT_BITS'(1);
    localparam logic [LAT_BITS-1:0] LAT_READ_DONE = LAT_BITS'(CAS_LATENCY + PRECHARGE_LATENCY);
    localparam logic [LAT_BITS-1:0] LAT_WRITE_DONE = LAT_BITS'(PRECHARGE_LATENCY + 1);

    localparam int TIMER_BITS = $clog2(INIT_CYCLES);
    localparam logic [TIMER_BITS-1:0] INIT_COUNT = TIMER_BITS'(INIT_CYCLES - 1);
    localparam logic [TIMER_BITS-1:0] REFRESH_COUNT = TIMER_BITS'(REFRESH_INTERVAL - 1);

    localparam int CAPTURE_SLOTS = CAS_LATENCY + 2;

    // {ncs, ras, cas, nwe}.
    typedef enum logic [3:0] {
        NOP       = 4'b0111,
        ACTIVATE  = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010,
        REFRESH   = 4'b0001,
        LOAD_MODE = 4'b0000
    } sdram_cmd_e;

    typedef struct packed {
        logic [ROW_BITS-1:0]      row;
        logic [BANK_BITS-1:0]     bank;
        logic [WORD_COL_BITS-1:0] col;
    } sdram_addr_fields_t;

    typedef union packed {
        logic [ADDR_BITS-1:0] index; // linear word index from the host.
        sdram_addr_fields_t   fields;
    } sdram_addr_u;

    typedef struct packed {
        sdram_cmd_e           cmd;
        logic [ROW_BITS-1:0]  addr;
        logic [BANK_BITS-1:0] ba;
        logic                 cke;
        logic [DQM_BITS-1:0]  dqm;
        logic [DQ_BITS-1:0]   data_out;
        logic                 data_noe;
    } sdram_pins_t;

endpackage

`default_nettype wire

// File: src/host_pkg.sv
`default_nettype none

package host_pkg;

    localparam int QUEUE_DEPTH = 8; // power of two, pointers wrap.
    localparam int TAG_BITS = 4;
    localparam int DATA_BITS = 32;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);
    localparam logic [COUNT_BITS-1:0] QUEUE_FULL = COUNT_BITS'(QUEUE_DEPTH);

    typedef struct packed {
        logic                   write;
        sdram_pkg::sdram_addr_u addr;
        logic [DATA_BITS-1:0]   wdata;
        logic [TAG_BITS-1:0]    tag;
    } host_req_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] rdata;
        logic [TAG_BITS-1:0]  tag;
    } host_rsp_t;

endpackage

`default_nettype wire

// File: src/sdram_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_req_queue (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 req_valid,
    input  wire host_pkg::host_req_t req,
    input  wire                 q_pop,
    output logic                q_valid,
    output host_pkg::host_req_t q_head,
    output logic                overflow
);

    host_pkg::host_req_t                mem [host_pkg::QUEUE_DEPTH];
    logic [host_pkg::PTR_BITS-1:0]      wr_ptr;
    logic [host_pkg::PTR_BITS-1:0]      rd_ptr;
    logic [host_pkg::COUNT_BITS-1:0]    count;
    logic                               full;
    logic                               push;
    logic                               pop;

    assign full = count == host_pkg::QUEUE_FULL;
    assign push = req_valid && !full;
    assign pop = q_pop && q_valid;
    assign q_valid = count != '0;
    assign q_head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (req_valid && full) overflow <= 1'b1; // strobe dropped.
        end
    end

endmodule

`default_nettype wire

// File: src/sdram_refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_timer (
    input  wire  clk,
    input  wire  reset,
    input  wire  refresh_ack,
    output logic init_wait_done,
    output logic refresh_due
);

    logic [sdram_pkg::TIMER_BITS-1:0] count;

    // one counter for the power-up wait, then the refresh period.
    always_ff @(posedge clk) begin
        if (reset) begin
            count          <= sdram_pkg::INIT_COUNT;
            init_wait_done <= 1'b0;
            refresh_due    <= 1'b0;
        end else begin
            if (refresh_ack) begin
                refresh_due <= 1'b0;
            end
            if (count == '0) begin
                count          <= sdram_pkg::REFRESH_COUNT;
                init_wait_done <= 1'b1;
                // init sequence does its own refreshes.
                if (init_wait_done) begin
                    refresh_due <= 1'b1; // at most one pending.
                end
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sdram_cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_sequencer (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           init_wait_done,
    input  wire                           refresh_due,
    output logic                          refresh_ack,
    input  wire                           q_valid,
    input  wire host_pkg::host_req_t      q_head,
    output logic                          q_pop,
    output sdram_pkg::sdram_pins_t        pins,
    output logic                          rd_issue,
    output logic [host_pkg::TAG_BITS-1:0] rd_tag,
    output logic                          ready
);

    typedef enum logic [2:0] {
        S_INIT_WAIT,
        S_INIT_PRECHARGE,
        S_INIT_REFRESH,
        S_INIT_MODE,
        S_IDLE,
        S_ACCESS,
        S_WRITE_HIGH
    } state_e;

    state_e                           state;
    logic [sdram_pkg::LAT_BITS-1:0]   lat_cnt;
    logic                             second_refresh;
    host_pkg::host_req_t              cur;
    logic [sdram_pkg::ROW_BITS-1:0]   col_addr;

    // even column of the word, a10 set for auto precharge.
    assign col_addr = sdram_pkg::AUTO_PRECHARGE
                    | {{(sdram_pkg::ROW_BITS - sdram_pkg::COL_BITS){1'b0}},
                       cur.addr.fields.col, 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= S_INIT_WAIT;
            lat_cnt        <= '0;
            second_refresh <= 1'b0;
            ready          <= 1'b0;
            q_pop          <= 1'b0;
            refresh_ack    <= 1'b0;
            rd_issue       <= 1'b0;
            pins.cmd       <= sdram_pkg::NOP;
            pins.cke       <= 1'b0;
            pins.dqm       <= '1;
            pins.data_noe  <= 1'b1;
        end else begin
            pins.cmd      <= sdram_pkg::NOP;
            pins.data_noe <= 1'b1;
            q_pop         <= 1'b0;
            refresh_ack   <= 1'b0;
            rd_issue      <= 1'b0;
            if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1; // nops.
            end else begin
                case (state)
                    S_INIT_WAIT: begin
                        if (init_wait_done) begin
                            pins.cke <= 1'b1;
                            state    <= S_INIT_PRECHARGE;
                        end
                    end
                    S_INIT_PRECHARGE: begin
                        pins.cmd  <= sdram_pkg::PRECHARGE; // all banks.
                        pins.addr <= sdram_pkg::AUTO_PRECHARGE;
                        pins.ba   <= '0;
                        lat_cnt   <= sdram_pkg::LAT_PRECHARGE;
                        state     <= S_INIT_REFRESH;
                    end
                    S_INIT_REFRESH: begin
                        pins.cmd       <= sdram_pkg::REFRESH;
                        lat_cnt        <= sdram_pkg::LAT_REFRESH;
                        second_refresh <= 1'b1;
                        if (second_refresh) begin
                            state <= S_INIT_MODE;
                        end
                    end
                    S_INIT_MODE: begin
                        pins.cmd  <= sdram_pkg::LOAD_MODE;
                        pins.addr <= sdram_pkg::MODE_REGISTER_VALUE;
                        pins.ba   <= '0;
                        lat_cnt   <= sdram_pkg::LAT_MODE; // ready two cycles later.
                        state     <= S_IDLE;
                    end
                    S_IDLE: begin
                        ready    <= 1'b1;
                        pins.dqm <= '0;
                        if (refresh_due) begin
                            pins.cmd    <= sdram_pkg::REFRESH; // refresh wins.
                            refresh_ack <= 1'b1;
                            lat_cnt     <= sdram_pkg::LAT_REFRESH;
                        end else if (q_valid) begin
                            pins.cmd  <= sdram_pkg::ACTIVATE;
                            pins.addr <= q_head.addr.fields.row;
                            pins.ba   <= q_head.addr.fields.bank;
                            cur       <= q_head;
                            q_pop     <= 1'b1;
                            lat_cnt   <= sdram_pkg::LAT_ACTIVATE;
                            state     <= S_ACCESS;
                        end
                    end
                    S_ACCESS: begin
                        pins.addr <= col_addr;
                        if (cur.write) begin
                            pins.cmd      <= sdram_pkg::WRITE;
                            pins.data_out <= cur.wdata[sdram_pkg::DQ_BITS-1:0];
                            pins.data_noe <= 1'b0;
                            state         <= S_WRITE_HIGH;
                        end else begin
                            pins.cmd <= sdram_pkg::READ;
                            rd_issue <= 1'b1;
                            rd_tag   <= cur.tag;
                            lat_cnt  <= sdram_pkg::LAT_READ_DONE; // burst plus precharge.
                            state    <= S_IDLE;
                        end
                    end
                    S_WRITE_HIGH: begin
                        pins.data_out <= cur.wdata[2*sdram_pkg::DQ_BITS-1:sdram_pkg::DQ_BITS];
                        pins.data_noe <= 1'b0;
                        lat_cnt       <= sdram_pkg::LAT_WRITE_DONE;
                        state         <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sdram_read_capture.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_read_capture (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          rd_issue,
    input  wire [host_pkg::TAG_BITS-1:0] rd_tag,
    input  wire [sdram_pkg::DQ_BITS-1:0] sdram_data_in,
    output logic                         rsp_valid,
    output host_pkg::host_rsp_t          rsp
);

    logic [sdram_pkg::CAPTURE_SLOTS-1:0] valid_sr;
    logic [host_pkg::TAG_BITS-1:0]       tag_sr [sdram_pkg::CAPTURE_SLOTS];
    logic [sdram_pkg::DQ_BITS-1:0]       low_beat;
    logic [sdram_pkg::DQ_BITS-1:0]       high_beat;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[sdram_pkg::CAPTURE_SLOTS-2:0], rd_issue};
        end
    end

    // slot i holds a read issued i+1 cycles ago.
    always_ff @(posedge clk) begin
        tag_sr[0] <= rd_tag;
        for (int i = 1; i < sdram_pkg::CAPTURE_SLOTS; i++) begin
            tag_sr[i] <= tag_sr[i-1];
        end
        if (valid_sr[sdram_pkg::CAS_LATENCY-1]) begin
            low_beat <= sdram_data_in;
        end
        if (valid_sr[sdram_pkg::CAS_LATENCY]) begin
            high_beat <= sdram_data_in;
        end
    end

    assign rsp_valid = valid_sr[sdram_pkg::CAPTURE_SLOTS-1];
    assign rsp.rdata = {high_beat, low_beat};
    assign rsp.tag = tag_sr[sdram_pkg::CAPTURE_SLOTS-1];

endmodule

`default_nettype wire

// File: src/sdram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsystem (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            req_valid,
    input  wire host_pkg::host_req_t       req,
    output logic                           rsp_valid,
    output host_pkg::host_rsp_t            rsp,
    output logic                           ready,
    output logic                           overflow,
    output logic                           sdram_clk,
    output logic                           sdram_cke,
    output logic [sdram_pkg::ROW_BITS-1:0]  sdram_address,
    output logic [sdram_pkg::BANK_BITS-1:0] sdram_ba,
    output logic                           sdram_ncs,
    output logic                           sdram_ras,
    output logic                           sdram_cas,
    output logic                           sdram_nwe,
    output logic [sdram_pkg::DQM_BITS-1:0]  sdram_dqm,
    output logic [sdram_pkg::DQ_BITS-1:0]   sdram_data_out,
    output logic                           sdram_data_noe,
    input  wire [sdram_pkg::DQ_BITS-1:0]    sdram_data_in
);

    logic                          q_valid;
    logic                          q_pop;
    host_pkg::host_req_t           q_head;
    logic                          init_wait_done;
    logic                          refresh_due;
    logic                          refresh_ack;
    sdram_pkg::sdram_pins_t        pins;
    logic                          rd_issue;
    logic [host_pkg::TAG_BITS-1:0] rd_tag;

    sdram_req_queue u_req_queue (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .q_pop     (q_pop),
        .q_valid   (q_valid),
        .q_head    (q_head),
        .overflow  (overflow)
    );

    sdram_refresh_timer u_refresh_timer (
        .clk            (clk),
        .reset          (reset),
        .refresh_ack    (refresh_ack),
        .init_wait_done (init_wait_done),
        .refresh_due    (refresh_due)
    );

    sdram_cmd_sequencer u_cmd_sequencer (
        .clk            (clk),
        .reset          (reset),
        .init_wait_done (init_wait_done),
        .refresh_due    (refresh_due),
        .refresh_ack    (refresh_ack),
        .q_valid        (q_valid),
        .q_head         (q_head),
        .q_pop          (q_pop),
        .pins           (pins),
        .rd_issue       (rd_issue),
        .rd_tag         (rd_tag),
        .ready          (ready)
    );

    sdram_read_capture u_read_capture (
        .clk           (clk),
        .reset         (reset),
        .rd_issue      (rd_issue),
        .rd_tag        (rd_tag),
        .sdram_data_in (sdram_data_in),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

    assign sdram_clk = clk; // device runs on the controller clock.
    assign sdram_cke = pins.cke;
    assign sdram_address = pins.addr;
    assign sdram_ba = pins.ba;
    assign {sdram_ncs, sdram_ras, sdram_cas, sdram_nwe} = pins.cmd;
    assign sdram_dqm = pins.dqm;
    assign sdram_data_out = pins.data_out;
    assign sdram_data_noe = pins.data_noe;

endmodule

`default_nettype wire

// File: tests/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                             clk,
    input  wire                             cke,
    input  wire [sdram_pkg::ROW_BITS-1:0]   address,
    input  wire [sdram_pkg::BANK_BITS-1:0]  ba,
    input  wire                             ncs,
    input  wire                             ras,
    input  wire                             cas,
    input  wire                             nwe,
    input  wire [sdram_pkg::DQ_BITS-1:0]    data_out,
    input  wire                             data_noe,
    output logic [sdram_pkg::DQ_BITS-1:0]   data_in
);

    logic [sdram_pkg::DQ_BITS-1:0]  mem [int];
    logic [sdram_pkg::ROW_BITS-1:0] open_row [4];
    logic [sdram_pkg::BANK_BITS-1:0] cur_bank;
    logic [sdram_pkg::COL_BITS-1:0]  cur_col;
    int                              rd_stage;
    logic                            wr_high;

    function automatic int beat_key(input logic [1:0] b, input logic [12:0] r,
                                    input logic [8:0] c);
        return int'({b, r, c});
    endfunction

    initial begin
        rd_stage = 0;
        wr_high = 1'b0;
        data_in = '0;
    end

    always @(posedge clk) begin
        if (cke) begin
            case ({ncs, ras, cas, nwe})
                sdram_pkg::ACTIVATE: open_row[ba] = address;
                sdram_pkg::READ: begin
                    cur_bank = ba;
                    cur_col = address[sdram_pkg::COL_BITS-1:0];
                    rd_stage = 1;
                end
                sdram_pkg::WRITE: begin
                    cur_bank = ba;
                    cur_col = address[sdram_pkg::COL_BITS-1:0];
                    if (!data_noe) mem[beat_key(ba, open_row[ba], cur_col)] = data_out;
                    wr_high = 1'b1;
                end
                default: begin
                    if (wr_high && !data_noe) begin // second beat of the burst.
                        mem[beat_key(cur_bank, open_row[cur_bank], cur_col + 1'b1)] = data_out;
                    end
                    wr_high = 1'b0;
                end
            endcase
            // cas latency 2 from the edge that saw READ.
            if (rd_stage == 2) begin
                data_in <= mem.exists(beat_key(cur_bank, open_row[cur_bank], cur_col))
                         ? mem[beat_key(cur_bank, open_row[cur_bank], cur_col)] : '0;
                rd_stage = 3;
            end else if (rd_stage == 3) begin
                data_in <= mem.exists(beat_key(cur_bank, open_row[cur_bank], cur_col + 1'b1))
                         ? mem[beat_key(cur_bank, open_row[cur_bank], cur_col + 1'b1)] : '0;
                rd_stage = 0;
            end else if (rd_stage == 1) begin
                rd_stage = 2;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/sdram_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_monitor (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             req_valid,
    input  wire host_pkg::host_req_t        req,
    input  wire                             rsp_valid,
    input  wire host_pkg::host_rsp_t        rsp,
    input  wire                             ready,
    input  wire                             overflow,
    input  wire [sdram_pkg::ROW_BITS-1:0]   address,
    input  wire [sdram_pkg::BANK_BITS-1:0]  ba,
    input  wire                             ncs,
    input  wire                             ras,
    input  wire                             cas,
    input  wire                             nwe,
    input  wire                             finish_check,
    output int                              error_count,
    output int                              check_count,
    output int                              q_count,
    output int                              pending_reads
);

    localparam int REFRESH_BOUND = sdram_pkg::REFRESH_INTERVAL + 16; // one access.

    logic [31:0]            shadow [int];
    sdram_pkg::sdram_addr_u addr_q [$];
    logic [3:0]             exp_tag [$];
    logic [31:0]            exp_data [$];
    logic                   exp_known [$];
    logic [7:0]             cur_col;
    logic                   exp_ovf;
    logic                   ready_seen;
    int                     init_step;
    int                     cycles;
    int                     ready_cycle;
    int                     last_refresh;
    int                     refresh_count;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        check_count++;
        if (exp !== got) begin
            error_count++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic report(input string msg);
        error_count++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(posedge clk) begin
        logic [3:0] cmd;
        logic       accepted;
        logic       popped;
        cmd = {ncs, ras, cas, nwe};
        if (reset) begin
            q_count <= 0;
            pending_reads <= 0;
            exp_ovf = 1'b0;
            ready_seen = 1'b0;
            init_step = 0;
            cycles = 0;
            refresh_count = 0;
        end else begin
            cycles++;
            popped = ready_seen && cmd == sdram_pkg::ACTIVATE;
            accepted = req_valid && q_count < host_pkg::QUEUE_DEPTH;
            compare("overflow", 32'(exp_ovf), 32'(overflow));
            if (req_valid && !accepted) exp_ovf = 1'b1; // flag shows next cycle.
            q_count <= q_count + int'(accepted) - int'(popped);

            if (!ready_seen && cmd != sdram_pkg::NOP) begin
                case (init_step)
                    0: if (cmd != sdram_pkg::PRECHARGE || !address[10])
                        report("init did not start with precharge all");
                    1, 2: if (cmd != sdram_pkg::REFRESH)
                        report("init refresh missing");
                    3: begin
                        if (cmd != sdram_pkg::LOAD_MODE) report("init mode load missing");
                        compare("sdram_address", 32'h21, 32'(address));
                    end
                    default: report("extra command during init");
                endcase
                init_step++;
            end
            if (ready && !ready_seen) begin
                ready_seen = 1'b1;
                if (init_step != 4) report("ready rose before the init sequence finished");
                if (cycles < sdram_pkg::INIT_CYCLES) report("ready rose before the init wait");
                ready_cycle = cycles;
                last_refresh = cycles;
            end else if (ready_seen) begin
                case (cmd)
                    sdram_pkg::REFRESH: begin
                        if (cycles - last_refresh > REFRESH_BOUND)
                            report("refresh interval too long");
                        last_refresh = cycles;
                        refresh_count++;
                    end
                    sdram_pkg::ACTIVATE: begin
                        if (addr_q.size() == 0) begin
                            report("activate without a queued request");
                        end else begin
                            compare("sdram_ba", 32'(addr_q[0].fields.bank), 32'(ba));
                            compare("sdram_address", 32'(addr_q[0].fields.row), 32'(address));
                            cur_col = addr_q[0].fields.col;
                            void'(addr_q.pop_front());
                        end
                    end
                    sdram_pkg::READ, sdram_pkg::WRITE: begin
                        compare("sdram_address", 32'({1'b1, 1'b0, cur_col, 1'b0}),
                                32'(address[10:0]));
                    end
                    default: ;
                endcase
            end

            if (rsp_valid) begin
                if (exp_tag.size() == 0) begin
                    report("response without an outstanding read");
                end else begin
                    compare("rsp.tag", 32'(exp_tag[0]), 32'(rsp.tag));
                    if (exp_known[0]) compare("rsp.rdata", exp_data[0], rsp.rdata);
                    void'(exp_tag.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_known.pop_front());
                end
            end
            if (accepted) begin
                addr_q.push_back(req.addr);
                if (req.write) begin
                    shadow[int'(req.addr.index)] = req.wdata;
                end else begin
                    exp_tag.push_back(req.tag);
                    exp_known.push_back(shadow.exists(int'(req.addr.index)));
                    exp_data.push_back(shadow.exists(int'(req.addr.index))
                                       ? shadow[int'(req.addr.index)] : 32'h0);
                end
            end
            pending_reads <= exp_tag.size();
            if (finish_check && refresh_count < (cycles - ready_cycle) / REFRESH_BOUND)
                report("too few refresh commands");
        end
    end

endmodule

`default_nettype wire

// File: tests/sdram_subsystem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_subsystem_chk (
    input wire       clk,
    input wire       reset,
    input wire       ready,
    input wire       cke,
    input wire [3:0] cmd,
    input wire       a10,
    input wire [1:0] dqm,
    input wire       data_noe
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (reset) !cke |-> cmd == sdram_pkg::NOP)
        else begin
            fail_count++;
            $error("command issued before cke");
        end

    // write beats only on the WRITE cycle and the one after.
    assert property (@(posedge clk) disable iff (reset)
        !data_noe |-> cmd == sdram_pkg::WRITE || $past(cmd) == sdram_pkg::WRITE)
        else begin
            fail_count++;
            $error("data driven outside a write burst");
        end

    assert property (@(posedge clk) disable iff (reset)
        (cmd == sdram_pkg::READ || cmd == sdram_pkg::WRITE) |-> a10)
        else begin
            fail_count++;
            $error("access without auto precharge");
        end

    assert property (@(posedge clk) disable iff (reset) ready |-> dqm == 2'b00)
        else begin
            fail_count++;
            $error("dqm masking after ready");
        end

endmodule

bind sdram_subsystem sdram_subsystem_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .cke      (sdram_cke),
    .cmd      ({sdram_ncs, sdram_ras, sdram_cas, sdram_nwe}),
    .a10      (sdram_address[10]),
    .dqm      (sdram_dqm),
    .data_noe (sdram_data_noe)
);

`default_nettype wire

// File: tests/tb_sdram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_subsystem;

    localparam int N_STIM = 28;
    localparam int ACCESS_BOUND = 32;

    typedef struct packed {
        logic        write;
        logic [22:0] addr;
        int          gap;
        int          group;
    } stim_t;

    stim_t stim [N_STIM] = '{
        '{1'b1, 23'h000010, 2, 0}, '{1'b0, 23'h000010, 4, 0},
        '{1'b1, 23'h0123ff, 1, 1}, '{1'b1, 23'h7fff00, 1, 1},
        '{1'b0, 23'h0123ff, 3, 1}, '{1'b0, 23'h7fff00, 0, 1},
        '{1'b0, 23'h000200, 2, 1}, // never written.
        '{1'b1, 23'h2a5140, 0, 2}, '{1'b1, 23'h2a5141, 0, 2},
        '{1'b1, 23'h2a5240, 0, 2}, '{1'b1, 23'h2a5341, 0, 2},
        '{1'b0, 23'h2a5140, 0, 2}, '{1'b0, 23'h2a5141, 0, 2},
        '{1'b0, 23'h2a5240, 0, 2}, '{1'b0, 23'h2a5341, 0, 2},
        '{1'b0, 23'h000010, 900, 3}, // idle long enough for refreshes.
        '{1'b1, 23'h000010, 1, 3}, '{1'b0, 23'h000010, 0, 3},
        '{1'b1, 23'h300000, 0, 4}, '{1'b1, 23'h300001, 0, 4},
        '{1'b1, 23'h300002, 0, 4}, '{1'b1, 23'h300003, 0, 4},
        '{1'b1, 23'h300004, 0, 4}, '{1'b1, 23'h300005, 0, 4},
        '{1'b1, 23'h300006, 0, 4}, '{1'b1, 23'h300007, 0, 4},
        '{1'b1, 23'h300008, 0, 4}, '{1'b1, 23'h300009, 0, 4}
    };

    logic                clk = 1'b0;
    logic                reset;
    logic                req_valid;
    host_pkg::host_req_t req;
    logic                rsp_valid;
    host_pkg::host_rsp_t rsp;
    logic                ready;
    logic                overflow;
    logic                sdram_clk;
    logic                sdram_cke;
    logic [12:0]         sdram_address;
    logic [1:0]          sdram_ba;
    logic                sdram_ncs;
    logic                sdram_ras;
    logic                sdram_cas;
    logic                sdram_nwe;
    logic [1:0]          sdram_dqm;
    logic [15:0]         sdram_data_out;
    logic                sdram_data_noe;
    logic [15:0]         sdram_data_in;
    logic                finish_check;
    int                  error_count;
    int                  check_count;
    int                  q_count;
    int                  pending_reads;
    int                  cycles = 0;
    int                  limit = 1 << 30;
    logic [31:0]         lcg_state = 32'h4b56_d1b7;

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    sdram_subsystem u_sdram_subsystem (.*);

    sdram_model u_model (
        .clk (sdram_clk), .cke (sdram_cke), .address (sdram_address), .ba (sdram_ba),
        .ncs (sdram_ncs), .ras (sdram_ras), .cas (sdram_cas), .nwe (sdram_nwe),
        .data_out (sdram_data_out), .data_noe (sdram_data_noe), .data_in (sdram_data_in)
    );

    sdram_monitor u_monitor (
        .clk (clk), .reset (reset), .req_valid (req_valid), .req (req),
        .rsp_valid (rsp_valid), .rsp (rsp), .ready (ready), .overflow (overflow),
        .address (sdram_address), .ba (sdram_ba), .ncs (sdram_ncs), .ras (sdram_ras),
        .cas (sdram_cas), .nwe (sdram_nwe), .finish_check (finish_check),
        .error_count (error_count), .check_count (check_count),
        .q_count (q_count), .pending_reads (pending_reads)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run passed %0d cycles without finishing", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int gap_sum;
        int total_errors;
        gap_sum = 0;
        for (int i = 0; i < N_STIM; i++) gap_sum += stim[i].gap;
        limit = (sdram_pkg::INIT_CYCLES + gap_sum + N_STIM * ACCESS_BOUND) * 2;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        finish_check = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (!ready) @(posedge clk);
        $display("test init: finished with %0d errors so far", error_count);
        for (int i = 0; i < N_STIM; i++) begin
            repeat (stim[i].gap) begin
                @(posedge clk);
                req_valid <= 1'b0;
            end
            @(posedge clk);
            lcg_state = lcg_next(lcg_state);
            req_valid <= 1'b1;
            req.write <= stim[i].write;
            req.addr.index <= stim[i].addr;
            req.wdata <= lcg_state;
            req.tag <= 4'(i);
            if (i == N_STIM - 1 || stim[i+1].group != stim[i].group) begin
                @(posedge clk);
                req_valid <= 1'b0;
                @(posedge clk);
                while (q_count != 0 || pending_reads != 0) @(posedge clk);
                $display("test group %0d: finished with %0d errors so far",
                         stim[i].group, error_count);
            end
        end
        repeat (8) @(posedge clk);
        finish_check <= 1'b1;
        @(posedge clk);
        finish_check <= 1'b0;
        repeat (2) @(posedge clk);
        total_errors = error_count + u_sdram_subsystem.u_chk.fail_count;
        $display("checks: %0d, errors: %0d", check_count, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/sdram_pkg.sv
src/host_pkg.sv
src/sdram_req_queue.sv
src/sdram_refresh_timer.sv
src/sdram_cmd_sequencer.sv
src/sdram_read_capture.sv
src/sdram_subsystem.sv
tests/sdram_model.sv
tests/sdram_monitor.sv
tests/sdram_subsystem_chk.sv
tests/tb_sdram_subsystem.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_sdram_subsystem -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && ! grep -q "Done: errors found" sim.log \
    && grep -q "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
